//--- aluPkg.sv
`default_nettype none

package aluPkg;

    // ============================================================
    // Widths and register map
    // ============================================================
    localparam int DATA_W = 32;                     // Bus and datapath word width
    localparam int ADDR_W = 5;                      // Byte address width

    localparam logic [ADDR_W-1:0] REG_OPA    = 5'h00; // Operand A, read/write
    localparam logic [ADDR_W-1:0] REG_OPB    = 5'h04; // Operand B, read/write
    localparam logic [ADDR_W-1:0] REG_CTRL   = 5'h08; // Op in [2:0], alt bit in [3]
    localparam logic [ADDR_W-1:0] REG_RESULT = 5'h0C; // Stored result, read only
    localparam logic [ADDR_W-1:0] REG_FLAGS  = 5'h10; // Stored flags, read only

    localparam int FLAG_ZERO  = 0;                  // Zero flag bit in REG_FLAGS
    localparam int FLAG_CARRY = 1;                  // Carry flag bit in REG_FLAGS

    // ============================================================
    // Encodings
    // ============================================================
    typedef enum logic [2:0] {
        ADD  = 3'd0,                                // Alt bit turns it into SUB
        SLL  = 3'd1,
        SLT  = 3'd2,
        SLTU = 3'd3,
        XOR  = 3'd4,
        SRL  = 3'd5,                                // Alt bit turns it into SRA
        OR   = 3'd6,
        AND  = 3'd7
    } aluOpE;                                       // Same codes as RISC-V funct3

    typedef enum logic {
        IDLE = 1'b0,                                // Ready to accept an access
        ACK  = 1'b1                                 // Ack cycle, new access ignored
    } wbStateE;

    // ============================================================
    // Structs
    // ============================================================
    typedef struct packed {
        logic  opAlt;                               // funct7 bit 5
        aluOpE op;
    } aluCtrlT;                                     // 4 bits, lives in REG_CTRL

    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic              zero;                    // Result is all zero
        logic              carry;                   // Adder carry-out, ADD/SUB only
    } aluResT;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wbReqT;                                       // Master to slave

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wbRspT;                                       // Slave to master

endpackage

`default_nettype wire

//--- carryLookaheadAdder.sv
`default_nettype none

module carryLookaheadAdder #(
    parameter int WIDTH = 32                        // Datapath width
) (
    input  logic [WIDTH-1:0] a,                     // Operand A
    input  logic [WIDTH-1:0] b,                     // Operand B
    input  logic             subEn,                 // Subtract, doubles as carry-in
    output logic [WIDTH-1:0] result,                // Sum or difference
    output logic             cout                   // Carry out of the top bit
);

    logic [WIDTH-1:0] bEff;                         // B, inverted when subtracting
    logic [WIDTH-1:0] propBits;                     // Per-bit propagate
    logic [WIDTH-1:0] genBits;                      // Per-bit generate
    logic [WIDTH:0]   carry;                        // carry[0] is the carry-in

    // Carry out of bit top, flattened into generate/propagate terms
    function automatic logic lookCarry(
        input logic [WIDTH-1:0] p,
        input logic [WIDTH-1:0] g,
        input logic             cin,
        input int               top
    );
        logic chainP;                               // Product of propagates seen so far
        logic acc;                                  // OR of generate terms
        chainP = 1'b1;
        acc    = 1'b0;
        for (int j = WIDTH - 1; j >= 0; j--) begin
            if (j <= top) begin                     // Walk down from bit top
                acc    = acc | (g[j] & chainP);
                chainP = chainP & p[j];
            end
        end
        return acc | (chainP & cin);                // Carry-in rippled through all
    endfunction

    assign bEff     = subEn ? ~b : b;               // Two's complement with carry-in
    assign propBits = a ^ bEff;
    assign genBits  = a & bEff;
    assign carry[0] = subEn;

    for (genvar i = 0; i < WIDTH; i++) begin : gCarry
        assign carry[i+1] = lookCarry(propBits, genBits, carry[0], i);
    end

    assign result = propBits ^ carry[WIDTH-1:0];
    assign cout   = carry[WIDTH];

endmodule

`default_nettype wire

//--- barrelShifter.sv
`default_nettype none

module barrelShifter #(
    parameter int WIDTH = 32                        // Datapath width
) (
    input  logic [WIDTH-1:0]         data,          // Value to shift
    input  logic [$clog2(WIDTH)-1:0] shamt,         // Low bits of the shift amount
    input  logic                     right,         // 1 right, 0 left
    input  logic                     arith,         // Sign fill on right shifts
    output logic [WIDTH-1:0]         result
);

    localparam int STAGES = $clog2(WIDTH);          // One mux stage per shamt bit

    logic [WIDTH-1:0] stage [0:STAGES];             // stage[0] is the input
    logic             fill;                         // Bit shifted in from the top

    // Mirror a word so a left shift becomes a right shift
    function automatic logic [WIDTH-1:0] bitRev(input logic [WIDTH-1:0] x);
        logic [WIDTH-1:0] y;
        for (int i = 0; i < WIDTH; i++) begin
            y[i] = x[WIDTH-1-i];
        end
        return y;
    endfunction

    // ============================================================
    // Input conditioning
    // ============================================================
    assign fill     = right & arith & data[WIDTH-1]; // Zero for left and logical
    assign stage[0] = right ? data : bitRev(data);

    // ============================================================
    // Shift stages, all shifting right
    // ============================================================
    for (genvar k = 0; k < STAGES; k++) begin : gStage
        localparam int SH = 1 << k;                 // Distance of this stage

        assign stage[k+1] = shamt[k] ? {{SH{fill}}, stage[k][WIDTH-1:SH]}
                                     : stage[k];
    end

    // Undo the mirroring for left shifts
    assign result = right ? stage[STAGES] : bitRev(stage[STAGES]);

endmodule

`default_nettype wire

//--- integerAlu.sv
`default_nettype none

module integerAlu #(
    parameter int WIDTH = 32                        // Datapath width
) (
    input  logic [WIDTH-1:0] opA,                   // Operand A
    input  logic [WIDTH-1:0] opB,                   // Operand B
    input  aluPkg::aluCtrlT  ctrl,                  // Opcode and alt bit
    output aluPkg::aluResT   res                    // Result and flags
);

    localparam int SHAMT_W = $clog2(WIDTH);         // RISC-V uses only the low bits

    logic             subEn;                        // Adder in subtract mode
    logic [WIDTH-1:0] addSum;
    logic             addCout;
    logic [WIDTH-1:0] shiftOut;
    logic             isRight;                      // SRL or SRA
    logic             ovf;                          // Signed overflow of A - B
    logic             ltSigned;
    logic             ltUnsigned;
    logic [WIDTH-1:0] aluOut;

    // ============================================================
    // Shared adder and shifter
    // ============================================================
    assign subEn = ((ctrl.op == aluPkg::ADD) & ctrl.opAlt)
                 | (ctrl.op == aluPkg::SLT)
                 | (ctrl.op == aluPkg::SLTU);       // Compares need A - B

    carryLookaheadAdder #(
        .WIDTH (WIDTH)
    ) i_adder (
        .a      (opA),
        .b      (opB),
        .subEn  (subEn),
        .result (addSum),
        .cout   (addCout)
    );

    assign isRight = (ctrl.op == aluPkg::SRL);

    barrelShifter #(
        .WIDTH (WIDTH)
    ) i_shifter (
        .data   (opA),
        .shamt  (opB[SHAMT_W-1:0]),
        .right  (isRight),
        .arith  (ctrl.opAlt),                       // SRA when set
        .result (shiftOut)
    );

    // ============================================================
    // Compares
    // ============================================================
    assign ovf        = (opA[WIDTH-1] ^ opB[WIDTH-1]) & (opA[WIDTH-1] ^ addSum[WIDTH-1]);
    assign ltSigned   = addSum[WIDTH-1] ^ ovf;      // Sign fixed up for overflow
    assign ltUnsigned = ~addCout;                   // Borrow out of A - B

    always_comb begin
        aluOut = '0;
        case (ctrl.op)
            aluPkg::ADD  : aluOut = addSum;         // ADD or SUB
            aluPkg::SLL  : aluOut = shiftOut;
            aluPkg::SLT  : aluOut = {{(WIDTH-1){1'b0}}, ltSigned};
            aluPkg::SLTU : aluOut = {{(WIDTH-1){1'b0}}, ltUnsigned};
            aluPkg::XOR  : aluOut = opA ^ opB;
            aluPkg::SRL  : aluOut = shiftOut;       // SRL or SRA
            aluPkg::OR   : aluOut = opA | opB;
            aluPkg::AND  : aluOut = opA & opB;
            default      : aluOut = '0;
        endcase
    end

    assign res.result = aluOut;
    assign res.zero   = (aluOut == '0);
    assign res.carry  = (ctrl.op == aluPkg::ADD) ? addCout : 1'b0; // Only add/sub carry

endmodule

`default_nettype wire

//--- aluWbSlave.sv
`default_nettype none

module aluWbSlave (
    input  logic                       clk,
    input  logic                       rstN,        // Async, active low
    input  aluPkg::wbReqT              wbReq,       // Wishbone request from master
    output aluPkg::wbRspT              wbRsp,       // Registered ack and read data
    output logic [aluPkg::DATA_W-1:0]  opA,         // Operand A register
    output logic [aluPkg::DATA_W-1:0]  opB,         // Operand B register
    output aluPkg::aluCtrlT            ctrl,        // Control register
    input  aluPkg::aluResT             aluRes       // Combinational ALU output
);

    localparam int CTRL_W = $bits(aluPkg::aluCtrlT);

    aluPkg::wbStateE            state;
    aluPkg::aluResT             resReg;             // Stored result and flags
    logic                       pending;            // Control written, latch next edge
    logic                       accept;             // Access taken this edge
    logic [aluPkg::DATA_W-1:0]  rdMux;              // Read data before the register

    assign accept = wbReq.cyc & wbReq.stb & (state == aluPkg::IDLE);

    // ============================================================
    // Read decode
    // ============================================================
    always_comb begin
        rdMux = '0;                                 // Unmapped reads return zero
        case (wbReq.adr)
            aluPkg::REG_OPA    : rdMux = opA;
            aluPkg::REG_OPB    : rdMux = opB;
            aluPkg::REG_CTRL   : rdMux[CTRL_W-1:0] = ctrl;
            aluPkg::REG_RESULT : rdMux = resReg.result;
            aluPkg::REG_FLAGS  : begin
                rdMux[aluPkg::FLAG_ZERO]  = resReg.zero;
                rdMux[aluPkg::FLAG_CARRY] = resReg.carry;
            end
            default            : rdMux = '0;
        endcase
    end

    // ============================================================
    // Handshake FSM, one ack per access
    // ============================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= aluPkg::IDLE;
            wbRsp.ack <= 1'b0;
            wbRsp.dat <= '0;
        end else begin
            case (state)
                aluPkg::IDLE : begin
                    if (accept) begin
                        wbRsp.ack <= 1'b1;
                        wbRsp.dat <= rdMux; // Valid alongside ack
                        state     <= aluPkg::ACK;
                    end
                end
                aluPkg::ACK : begin
                    wbRsp.ack <= 1'b0;      // Held stb is ignored here
                    state     <= aluPkg::IDLE;
                end
                default : begin
                    wbRsp.ack <= 1'b0;
                    state     <= aluPkg::IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // Register writes and result capture
    // ============================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opA     <= '0;
            opB     <= '0;
            ctrl    <= '0;
            resReg  <= '0;
            pending <= 1'b0;
        end else begin
            if (pending) begin
                resReg  <= aluRes;                  // ALU already sees new ctrl
                pending <= 1'b0;
            end
            if (accept && wbReq.we) begin
                case (wbReq.adr)
                    aluPkg::REG_OPA  : opA <= wbReq.dat;
                    aluPkg::REG_OPB  : opB <= wbReq.dat;
                    aluPkg::REG_CTRL : begin
                        ctrl    <= aluPkg::aluCtrlT'(wbReq.dat[CTRL_W-1:0]);
                        pending <= 1'b1;
                    end
                    default          : ;            // Read-only or unmapped, dropped
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- aluSubsystem.sv
`default_nettype none

module aluSubsystem #(
    parameter int WIDTH = aluPkg::DATA_W            // ALU datapath width
) (
    input  logic          clk,
    input  logic          rstN,                     // Async, active low
    input  aluPkg::wbReqT wbReq,                    // Wishbone classic request
    output aluPkg::wbRspT wbRsp                     // Wishbone classic response
);

    // ============================================================
    // Slave to ALU nets
    // ============================================================
    logic [WIDTH-1:0] opA;
    logic [WIDTH-1:0] opB;
    aluPkg::aluCtrlT  ctrl;
    aluPkg::aluResT   aluRes;

    aluWbSlave i_slave (
        .clk    (clk),
        .rstN   (rstN),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .opA    (opA),
        .opB    (opB),
        .ctrl   (ctrl),
        .aluRes (aluRes)                            // Captured one edge after ctrl write
    );

    integerAlu #(
        .WIDTH (WIDTH)
    ) i_alu (
        .opA  (opA),
        .opB  (opB),
        .ctrl (ctrl),
        .res  (aluRes)
    );

endmodule

`default_nettype wire

//--- aluSubsystem_chk.sv
`default_nettype none

module aluSubsystem_chk (
    input logic          clk,
    input logic          rstN,
    input aluPkg::wbReqT wbReq,                     // Request as seen by the DUT
    input aluPkg::wbRspT wbRsp                      // Response from the DUT
);
    timeunit 1ns;
    timeprecision 1ps;

    // ============================================================
    // Wishbone classic slave protocol
    // ============================================================
    ackOnePulse: assert property (@(posedge clk) disable iff (!rstN)
        wbRsp.ack |=> !wbRsp.ack)
        else $error("ack stayed high for more than one cycle");

    ackAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))  // No ack without a request
        else $error("ack raised without cyc and stb in the cycle before");

    ackLowInReset: assert property (@(posedge clk)
        !rstN |-> !wbRsp.ack)
        else $error("ack high while reset is asserted");

    readDataKnown: assert property (@(posedge clk) disable iff (!rstN)
        wbRsp.ack |-> !$isunknown(wbRsp.dat))
        else $error("read data has X or Z bits while ack is high");

endmodule

bind aluSubsystem aluSubsystem_chk i_chk (
    .clk   (clk),
    .rstN  (rstN),
    .wbReq (wbReq),
    .wbRsp (wbRsp)
);

`default_nettype wire

//--- aluSubsystemTb.sv
`default_nettype none

module aluSubsystemTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VECS    = 22;                // Directed table rows
    localparam int NUM_RAND    = 20;                // Random rows after the table
    localparam int ACK_TIMEOUT = 16;                // Cycles allowed for one ack

    typedef struct packed {
        logic [31:0]   a;
        logic [31:0]   b;
        aluPkg::aluOpE op;
        logic          alt;                         // funct7 bit 5
        logic [31:0]   expRes;
        logic          expZero;
        logic          expCarry;
    } vecT;

    logic          clk;
    logic          rstN;
    aluPkg::wbReqT wbReq;
    aluPkg::wbRspT wbRsp;
    vecT           vecs [NUM_VECS];
    int            errors;
    int            checks;
    logic [31:0]   rdData;
    logic [31:0]   ra;                              // Random operand A
    logic [31:0]   rb;                              // Random operand B
    aluPkg::aluOpE rOp;
    logic          rAlt;
    logic [33:0]   refOut;                          // {result, zero, carry}

    aluSubsystem #(
        .WIDTH (aluPkg::DATA_W)
    ) i_dut (
        .clk   (clk),
        .rstN  (rstN),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    always begin
        #5 clk = ~clk;                              // 10 ns period
    end

    // ============================================================
    // Check and bus tasks
    // ============================================================
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    // One classic single transfer, held until ack
    task automatic busTransfer(input logic we, input logic [4:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        aluPkg::wbReqT req;
        int            waited;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        rdat    = 'x;
        waited  = 0;
        @(posedge clk);
        wbReq <= req;
        do begin
            @(negedge clk);                         // Ack and data settled here
            waited++;
        end while (!wbRsp.ack && waited < ACK_TIMEOUT);
        if (wbRsp.ack) begin
            rdat = wbRsp.dat;
        end else begin
            errors++;
            $display("Timeout: no ack within %0d cycles for a %s at address 0x%02h",
                     ACK_TIMEOUT, we ? "write" : "read", adr);
        end
        @(posedge clk);
        wbReq <= '0;                                // Drop cyc/stb while slave is in ACK
    endtask

    task automatic wbWrite(input logic [4:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        busTransfer(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(input logic [4:0] adr, output logic [31:0] dat);
        busTransfer(1'b0, adr, 32'h0, dat);
    endtask

    // Load operands, start the op, read result and flags back
    task automatic applyOp(input logic [31:0] a, input logic [31:0] b,
                           input aluPkg::aluOpE op, input logic alt,
                           input logic [31:0] expRes, input logic expZero,
                           input logic expCarry);
        logic [31:0] rd;
        wbWrite(aluPkg::REG_OPA, a);
        wbWrite(aluPkg::REG_OPB, b);
        wbWrite(aluPkg::REG_CTRL, {28'd0, alt, op});
        wbRead(aluPkg::REG_RESULT, rd);
        checkValue($sformatf("REG_RESULT %s alt=%0b", op.name(), alt), expRes, rd);
        wbRead(aluPkg::REG_FLAGS, rd);
        checkValue($sformatf("REG_FLAGS %s alt=%0b", op.name(), alt),
                   {30'd0, expCarry, expZero}, rd);
    endtask

    // Expected values straight from the RISC-V semantics
    function automatic logic [33:0] refAlu(input logic [31:0] a, input logic [31:0] b,
                                           input aluPkg::aluOpE op, input logic alt);
        logic [32:0] sum;
        logic [31:0] r;
        logic        c;
        logic [4:0]  sh;
        sh = b[4:0];                                // Low five bits only
        c  = 1'b0;
        case (op)
            aluPkg::ADD : begin
                sum = alt ? {1'b0, a} + {1'b0, ~b} + 33'd1 : {1'b0, a} + {1'b0, b};
                r   = sum[31:0];
                c   = sum[32];
            end
            aluPkg::SLL  : r = a << sh;
            aluPkg::SLT  : r = {31'd0, ($signed(a) < $signed(b))};
            aluPkg::SLTU : r = {31'd0, (a < b)};
            aluPkg::XOR  : r = a ^ b;
            aluPkg::SRL  : begin
                if (alt) begin
                    r = $signed(a) >>> sh;          // Sign fill for SRA
                end else begin
                    r = a >> sh;
                end
            end
            aluPkg::OR   : r = a | b;
            default      : r = a & b;
        endcase
        return {r, (r == 32'd0), c};
    endfunction

    // ============================================================
    // Directed table
    // ============================================================
    task automatic loadVectors();
        vecs[0]  = '{32'hFFFFFFFF, 32'h00000001, aluPkg::ADD,  1'b0, 32'h00000000, 1'b1, 1'b1};
        vecs[1]  = '{32'h00000005, 32'h00000007, aluPkg::ADD,  1'b0, 32'h0000000C, 1'b0, 1'b0};
        vecs[2]  = '{32'h00000005, 32'h00000005, aluPkg::ADD,  1'b1, 32'h00000000, 1'b1, 1'b1};
        vecs[3]  = '{32'h00000003, 32'h00000005, aluPkg::ADD,  1'b1, 32'hFFFFFFFE, 1'b0, 1'b0};
        vecs[4]  = '{32'hF0F0F0F0, 32'hFF00FF00, aluPkg::AND,  1'b0, 32'hF000F000, 1'b0, 1'b0};
        vecs[5]  = '{32'hF0F0F0F0, 32'h0F0F0F0F, aluPkg::OR,   1'b0, 32'hFFFFFFFF, 1'b0, 1'b0};
        vecs[6]  = '{32'hAAAAAAAA, 32'hAAAAAAAA, aluPkg::XOR,  1'b0, 32'h00000000, 1'b1, 1'b0};
        vecs[7]  = '{32'h12345678, 32'hFFFFFFFF, aluPkg::XOR,  1'b0, 32'hEDCBA987, 1'b0, 1'b0};
        vecs[8]  = '{32'h00000001, 32'h00000000, aluPkg::SLL,  1'b0, 32'h00000001, 1'b0, 1'b0};
        vecs[9]  = '{32'h80000001, 32'h00000001, aluPkg::SLL,  1'b0, 32'h00000002, 1'b0, 1'b0};
        vecs[10] = '{32'h00000001, 32'h0000001F, aluPkg::SLL,  1'b0, 32'h80000000, 1'b0, 1'b0};
        vecs[11] = '{32'h00000003, 32'h00000021, aluPkg::SLL,  1'b0, 32'h00000006, 1'b0, 1'b0};
        vecs[12] = '{32'h80000000, 32'h0000001F, aluPkg::SRL,  1'b0, 32'h00000001, 1'b0, 1'b0};
        vecs[13] = '{32'h12345678, 32'h00000021, aluPkg::SRL,  1'b0, 32'h091A2B3C, 1'b0, 1'b0};
        vecs[14] = '{32'h80000000, 32'h00000001, aluPkg::SRL,  1'b1, 32'hC0000000, 1'b0, 1'b0};
        vecs[15] = '{32'hF0000000, 32'h00000021, aluPkg::SRL,  1'b1, 32'hF8000000, 1'b0, 1'b0};
        vecs[16] = '{32'hFFFFFFF0, 32'h0000001F, aluPkg::SRL,  1'b1, 32'hFFFFFFFF, 1'b0, 1'b0};
        vecs[17] = '{32'h7FFFFFFF, 32'h00000001, aluPkg::SRL,  1'b1, 32'h3FFFFFFF, 1'b0, 1'b0};
        vecs[18] = '{32'hFFFFFFFF, 32'h00000001, aluPkg::SLT,  1'b0, 32'h00000001, 1'b0, 1'b0};
        vecs[19] = '{32'hFFFFFFFF, 32'h00000001, aluPkg::SLTU, 1'b0, 32'h00000000, 1'b1, 1'b0};
        vecs[20] = '{32'h80000000, 32'h7FFFFFFF, aluPkg::SLT,  1'b0, 32'h00000001, 1'b0, 1'b0};
        vecs[21] = '{32'h00000001, 32'hFFFFFFFF, aluPkg::SLTU, 1'b0, 32'h00000001, 1'b0, 1'b0};
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        clk    = 1'b0;
        rstN   = 1'b0;
        wbReq  = '0;
        errors = 0;
        checks = 0;
        void'($urandom(32'h33f4));                  // Single seed for the run
        loadVectors();
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        wbRead(aluPkg::REG_RESULT, rdData);         // Reset state
        checkValue("REG_RESULT after reset", 32'h0, rdData);
        wbRead(aluPkg::REG_FLAGS, rdData);
        checkValue("REG_FLAGS after reset", 32'h0, rdData);
        wbWrite(aluPkg::REG_RESULT, 32'hDEADBEEF);  // Read-only result ignores writes
        wbRead(aluPkg::REG_RESULT, rdData);
        checkValue("REG_RESULT after write", 32'h0, rdData);
        wbWrite(aluPkg::REG_FLAGS, 32'h00000003);   // Read-only flags ignore writes
        wbRead(aluPkg::REG_FLAGS, rdData);
        checkValue("REG_FLAGS after write", 32'h0, rdData);
        wbWrite(aluPkg::REG_OPA, 32'hA5A50001);
        wbRead(aluPkg::REG_OPA, rdData);
        checkValue("REG_OPA", 32'hA5A50001, rdData);
        wbWrite(aluPkg::REG_OPB, 32'h00005A5A);
        wbRead(aluPkg::REG_OPB, rdData);
        checkValue("REG_OPB", 32'h00005A5A, rdData);
        wbWrite(aluPkg::REG_CTRL, 32'hFFFFFFF6);    // Only 4 bits stored
        wbRead(aluPkg::REG_CTRL, rdData);
        checkValue("REG_CTRL", 32'h00000006, rdData);

        for (int i = 0; i < NUM_VECS; i++) begin
            applyOp(vecs[i].a, vecs[i].b, vecs[i].op, vecs[i].alt,
                    vecs[i].expRes, vecs[i].expZero, vecs[i].expCarry);
        end

        for (int i = 0; i < NUM_RAND; i++) begin
            ra     = $urandom();
            rb     = $urandom();
            rOp    = aluPkg::aluOpE'(3'($urandom()));
            rAlt   = 1'($urandom());
            refOut = refAlu(ra, rb, rOp, rAlt);
            applyOp(ra, rb, rOp, rAlt, refOut[33:2], refOut[1], refOut[0]);
        end

        wbWrite(aluPkg::REG_OPA, ~ra);              // Operand write leaves result alone
        wbRead(aluPkg::REG_RESULT, rdData);
        checkValue("REG_RESULT after operand write", refOut[33:2], rdData);
        wbWrite(aluPkg::REG_CTRL, 32'h0);           // ADD picks up the new operand
        wbRead(aluPkg::REG_RESULT, rdData);
        checkValue("REG_RESULT after ctrl write", ~ra + rb, rdData);
        wbWrite(5'h18, 32'h12345678);               // Unmapped address is acked and dropped
        wbRead(5'h18, rdData);
        checkValue("unmapped 0x18", 32'h0, rdData);
        wbRead(5'h14, rdData);
        checkValue("unmapped 0x14", 32'h0, rdData);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
aluPkg.sv
carryLookaheadAdder.sv
barrelShifter.sv
integerAlu.sv
aluWbSlave.sv
aluSubsystem.sv
aluSubsystem_chk.sv
aluSubsystemTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := aluSubsystemTb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
